// File: Bender.yml
package:
  name: bpfcap

sources:
  - files:
      - rtl/avalon_pkg.sv
      - rtl/bpfcap_pkg.sv
      - rtl/bpfcap_csr.sv
      - rtl/bpfcap_reader.sv
      - rtl/bpfcap_filter.sv
      - rtl/bpfcap_writer.sv
      - rtl/bpfcap_top.sv
  - target: test
    files:
      - test/bpfcap_asserts.sv
      - test/tb_top.sv

// File: bpfcap.f
rtl/avalon_pkg.sv
rtl/bpfcap_pkg.sv
rtl/bpfcap_csr.sv
rtl/bpfcap_reader.sv
rtl/bpfcap_filter.sv
rtl/bpfcap_writer.sv
rtl/bpfcap_top.sv
test/bpfcap_asserts.sv
test/tb_top.sv

// File: rtl/avalon_pkg.sv
package avalon_pkg;

    // all addresses count 32-bit words
    typedef logic [31:0] mm_addr_t;
    typedef logic [31:0] mm_data_t;
    typedef logic [15:0] burst_t;

    // read master command, held while waitrequest is high
    typedef struct packed {
        logic     read;
        mm_addr_t address;
        burst_t   burstcount;
    } rd_req_t;

    // write master beat, address and burstcount hold for the whole burst
    typedef struct packed {
        logic     write;
        mm_addr_t address;
        mm_data_t writedata;
        burst_t   burstcount;
    } wr_req_t;

endpackage

// File: rtl/bpfcap_csr.sv
`timescale 1ns/1ps

module bpfcap_csr #(
    parameter int MAX_WORDS = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  bpfcap_pkg::csr_addr_e avs_s0_address,
    input  logic                  avs_s0_read,
    input  logic                  avs_s0_write,
    input  avalon_pkg::mm_data_t  avs_s0_writedata,
    input  logic                  pkt_done,
    input  logic                  pkt_matched,
    input  logic                  wr_done,
    output avalon_pkg::mm_data_t  avs_s0_readdata,
    output bpfcap_pkg::cap_cfg_t  cfg,
    output logic                  start
);

    typedef enum logic [1:0] {IDLE, RUN, WRITE} state_e;

    state_e                  state;
    avalon_pkg::mm_addr_t    pkt_begin;
    avalon_pkg::mm_addr_t    pkt_end;
    avalon_pkg::mm_addr_t    dst;
    avalon_pkg::mm_addr_t    offset;
    avalon_pkg::mm_data_t    value;
    avalon_pkg::mm_data_t    mask;
    avalon_pkg::mm_data_t    count;
    avalon_pkg::mm_data_t    diff;
    bpfcap_pkg::cap_status_t status;
    logic                    len_ok;
    logic                    start_req;

    // a negative difference shows up as bit 31 set
    assign diff   = pkt_end - pkt_begin;
    assign len_ok = !diff[31] && (diff != '0) &&
                    (diff <= avalon_pkg::mm_data_t'(MAX_WORDS));

    assign start_req = avs_s0_write && (avs_s0_address == bpfcap_pkg::CSR_CONTROL) &&
                       avs_s0_writedata[bpfcap_pkg::CTRL_START] && (state == IDLE);

    assign cfg = '{pkt_begin: pkt_begin,
                   length:    avalon_pkg::burst_t'(diff),
                   dst:       dst,
                   offset:    offset,
                   value:     value,
                   mask:      mask};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_begin <= '0;
            pkt_end   <= '0;
            dst       <= '0;
            offset    <= '0;
            value     <= '0;
            mask      <= '0;
        end else if (avs_s0_write) begin
            case (avs_s0_address)
                bpfcap_pkg::CSR_PKT_BEGIN: pkt_begin <= avs_s0_writedata;
                bpfcap_pkg::CSR_PKT_END:   pkt_end   <= avs_s0_writedata;
                bpfcap_pkg::CSR_DST:       dst       <= avs_s0_writedata;
                bpfcap_pkg::CSR_OFFSET:    offset    <= avs_s0_writedata;
                bpfcap_pkg::CSR_VALUE:     value     <= avs_s0_writedata;
                bpfcap_pkg::CSR_MASK:      mask      <= avs_s0_writedata;
                // control is handled by the FSM, count is read only
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            status <= '0;
            count  <= '0;
            start  <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_req && len_ok) begin
                        start  <= 1'b1;
                        status <= '{busy: 1'b1, default: 1'b0};
                        state  <= RUN;
                    end else if (start_req) begin
                        // refused, nothing is started
                        status <= '{done: 1'b1, error: 1'b1, default: 1'b0};
                    end
                end
                RUN: begin
                    if (pkt_done && pkt_matched) begin
                        state <= WRITE;
                    end else if (pkt_done) begin
                        status.busy <= 1'b0;
                        status.done <= 1'b1;
                        state       <= IDLE;
                    end
                end
                WRITE: begin
                    // copy finished, the capture now counts
                    if (wr_done) begin
                        status.busy    <= 1'b0;
                        status.done    <= 1'b1;
                        status.matched <= 1'b1;
                        count          <= count + 1'b1;
                        state          <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // fixed read latency of one cycle
    always_ff @(posedge clk) begin
        if (avs_s0_read) begin
            case (avs_s0_address)
                bpfcap_pkg::CSR_CONTROL:   avs_s0_readdata <= {28'd0, status};
                bpfcap_pkg::CSR_PKT_BEGIN: avs_s0_readdata <= pkt_begin;
                bpfcap_pkg::CSR_PKT_END:   avs_s0_readdata <= pkt_end;
                bpfcap_pkg::CSR_DST:       avs_s0_readdata <= dst;
                bpfcap_pkg::CSR_OFFSET:    avs_s0_readdata <= offset;
                bpfcap_pkg::CSR_VALUE:     avs_s0_readdata <= value;
                bpfcap_pkg::CSR_MASK:      avs_s0_readdata <= mask;
                bpfcap_pkg::CSR_COUNT:     avs_s0_readdata <= count;
                default:                   avs_s0_readdata <= '0;
            endcase
        end
    end

endmodule

// File: rtl/bpfcap_filter.sv
`timescale 1ns/1ps

module bpfcap_filter #(
    parameter int MAX_WORDS = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  bpfcap_pkg::cap_cfg_t cfg,
    input  avalon_pkg::mm_data_t rd_word,
    input  logic                 rd_valid,
    input  logic                 out_ready,
    output logic                 rd_ready,
    output avalon_pkg::mm_data_t out_word,
    output logic                 out_valid,
    output avalon_pkg::burst_t   out_len,
    output logic                 pkt_done,
    output logic                 pkt_matched
);

    localparam int IDX_W = $clog2(MAX_WORDS);

    typedef logic [IDX_W-1:0] idx_t;
    typedef enum logic [1:0] {FILL, DECIDE, DRAIN} state_e;

    state_e               state;
    avalon_pkg::mm_data_t buffer [MAX_WORDS];
    idx_t                 wr_idx;
    idx_t                 rd_idx;
    idx_t                 last_idx;
    logic                 hit;
    logic                 word_in;
    logic                 word_out;
    logic                 rule_hit;

    assign last_idx = idx_t'(cfg.length - 1'b1);
    assign word_in  = rd_valid && rd_ready;
    assign word_out = out_valid && out_ready;

    // an offset at or past the length is never reached by wr_idx
    assign rule_hit = (cfg.offset == avalon_pkg::mm_addr_t'(wr_idx)) &&
                      ((rd_word & cfg.mask) == (cfg.value & cfg.mask));

    assign rd_ready    = (state == FILL);
    assign out_valid   = (state == DRAIN);
    assign out_word    = buffer[rd_idx];
    assign pkt_done    = (state == DECIDE);
    assign pkt_matched = hit;

    always_ff @(posedge clk) begin
        if (word_in) begin
            buffer[wr_idx] <= rd_word;
        end
        if (state == DECIDE) begin
            out_len <= cfg.length;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= FILL;
            wr_idx <= '0;
            rd_idx <= '0;
            hit    <= 1'b0;
        end else begin
            case (state)
                FILL: begin
                    if (start) begin
                        wr_idx <= '0;
                        hit    <= 1'b0;
                    end else if (word_in) begin
                        if (rule_hit) begin
                            hit <= 1'b1;
                        end
                        if (wr_idx == last_idx) begin
                            state <= DECIDE;
                        end else begin
                            wr_idx <= wr_idx + 1'b1;
                        end
                    end
                end
                // a miss simply drops what was buffered
                DECIDE: begin
                    rd_idx <= '0;
                    state  <= hit ? DRAIN : FILL;
                end
                DRAIN: begin
                    if (word_out) begin
                        if (rd_idx == last_idx) begin
                            state <= FILL;
                        end else begin
                            rd_idx <= rd_idx + 1'b1;
                        end
                    end
                end
                default: state <= FILL;
            endcase
        end
    end

endmodule

// File: rtl/bpfcap_pkg.sv
package bpfcap_pkg;

    // s0 register map
    typedef enum logic [2:0] {
        CSR_CONTROL   = 3'd0,
        CSR_PKT_BEGIN = 3'd1,
        CSR_PKT_END   = 3'd2,
        CSR_DST       = 3'd3,
        CSR_OFFSET    = 3'd4,
        CSR_VALUE     = 3'd5,
        CSR_MASK      = 3'd6,
        CSR_COUNT     = 3'd7
    } csr_addr_e;

    // length is pkt_end - pkt_begin, only meaningful once checked by the slave
    typedef struct packed {
        avalon_pkg::mm_addr_t pkt_begin;
        avalon_pkg::burst_t   length;
        avalon_pkg::mm_addr_t dst;
        avalon_pkg::mm_addr_t offset;
        avalon_pkg::mm_data_t value;
        avalon_pkg::mm_data_t mask;
    } cap_cfg_t;

    // read back in bits 3..0 of CSR_CONTROL, busy in bit 3
    typedef struct packed {
        logic busy;
        logic done;
        logic matched;
        logic error;
    } cap_status_t;

    localparam int CTRL_START = 0;

endpackage

// File: rtl/bpfcap_reader.sv
`timescale 1ns/1ps

module bpfcap_reader #(
    parameter int MAX_WORDS = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  bpfcap_pkg::cap_cfg_t cfg,
    input  avalon_pkg::mm_data_t avs_m0_readdata,
    input  logic                 avs_m0_readdatavalid,
    input  logic                 avs_m0_waitrequest,
    input  logic                 rd_ready,
    output avalon_pkg::rd_req_t  m0_req,
    output avalon_pkg::mm_data_t rd_word,
    output logic                 rd_valid
);

    localparam int CNT_W = $clog2(MAX_WORDS + 1);

    typedef logic [CNT_W-1:0] cnt_t;
    typedef enum logic [1:0] {IDLE, CMD, DATA} state_e;

    state_e state;
    cnt_t   beats_left;
    logic   beat;

    // beats outside a burst are ignored
    assign beat = avs_m0_readdatavalid && (state != IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            m0_req     <= '0;
            beats_left <= '0;
            rd_valid   <= 1'b0;
        end else begin
            if (beat) begin
                rd_valid <= 1'b1;
            end else if (rd_ready) begin
                rd_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        m0_req.read       <= 1'b1;
                        m0_req.address    <= cfg.pkt_begin;
                        m0_req.burstcount <= cfg.length;
                        beats_left        <= cnt_t'(cfg.length);
                        state             <= CMD;
                    end
                end
                // command holds until the slave takes it
                CMD: begin
                    if (!avs_m0_waitrequest) begin
                        m0_req.read <= 1'b0;
                        state       <= DATA;
                    end
                end
                default: ;
            endcase
            if (beat) begin
                beats_left <= beats_left - 1'b1;
                if (beats_left == cnt_t'(1)) begin
                    state <= IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            rd_word <= avs_m0_readdata;
        end
    end

endmodule

// File: rtl/bpfcap_top.sv
`timescale 1ns/1ps

module bpfcap_top #(
    parameter int MAX_WORDS = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [2:0]           avs_s0_address,
    input  logic                 avs_s0_read,
    input  logic                 avs_s0_write,
    input  avalon_pkg::mm_data_t avs_s0_writedata,
    output avalon_pkg::mm_data_t avs_s0_readdata,
    output avalon_pkg::mm_addr_t avs_m0_address,
    output logic                 avs_m0_read,
    output avalon_pkg::burst_t   avs_m0_burstcount,
    input  avalon_pkg::mm_data_t avs_m0_readdata,
    input  logic                 avs_m0_readdatavalid,
    input  logic                 avs_m0_waitrequest,
    output avalon_pkg::mm_addr_t avs_m1_address,
    output logic                 avs_m1_write,
    output avalon_pkg::mm_data_t avs_m1_writedata,
    output avalon_pkg::burst_t   avs_m1_burstcount,
    input  logic                 avs_m1_waitrequest
);

    bpfcap_pkg::cap_cfg_t cfg;
    avalon_pkg::rd_req_t  m0_req;
    avalon_pkg::wr_req_t  m1_req;
    avalon_pkg::mm_data_t rd_word;
    avalon_pkg::mm_data_t out_word;
    avalon_pkg::burst_t   out_len;
    logic                 start;
    logic                 rd_valid;
    logic                 rd_ready;
    logic                 out_valid;
    logic                 out_ready;
    logic                 pkt_done;
    logic                 pkt_matched;
    logic                 wr_done;

    // flatten the master requests onto the bus ports
    assign avs_m0_read       = m0_req.read;
    assign avs_m0_address    = m0_req.address;
    assign avs_m0_burstcount = m0_req.burstcount;
    assign avs_m1_write      = m1_req.write;
    assign avs_m1_address    = m1_req.address;
    assign avs_m1_writedata  = m1_req.writedata;
    assign avs_m1_burstcount = m1_req.burstcount;

    bpfcap_csr #(
        .MAX_WORDS(MAX_WORDS)
    ) csr_i (
        .clk,
        .rst_n,
        .avs_s0_address  (bpfcap_pkg::csr_addr_e'(avs_s0_address)),
        .avs_s0_read,
        .avs_s0_write,
        .avs_s0_writedata,
        .pkt_done,
        .pkt_matched,
        .wr_done,
        .avs_s0_readdata,
        .cfg,
        .start
    );

    bpfcap_reader #(
        .MAX_WORDS(MAX_WORDS)
    ) reader_i (
        .clk,
        .rst_n,
        .start,
        .cfg,
        .avs_m0_readdata,
        .avs_m0_readdatavalid,
        .avs_m0_waitrequest,
        .rd_ready,
        .m0_req,
        .rd_word,
        .rd_valid
    );

    bpfcap_filter #(
        .MAX_WORDS(MAX_WORDS)
    ) filter_i (
        .clk,
        .rst_n,
        .start,
        .cfg,
        .rd_word,
        .rd_valid,
        .out_ready,
        .rd_ready,
        .out_word,
        .out_valid,
        .out_len,
        .pkt_done,
        .pkt_matched
    );

    bpfcap_writer writer_i (
        .clk,
        .rst_n,
        .cfg,
        .out_word,
        .out_valid,
        .out_len,
        .avs_m1_waitrequest,
        .out_ready,
        .m1_req,
        .wr_done
    );

endmodule

// File: rtl/bpfcap_writer.sv
`timescale 1ns/1ps

module bpfcap_writer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bpfcap_pkg::cap_cfg_t cfg,
    input  avalon_pkg::mm_data_t out_word,
    input  logic                 out_valid,
    input  avalon_pkg::burst_t   out_len,
    input  logic                 avs_m1_waitrequest,
    output logic                 out_ready,
    output avalon_pkg::wr_req_t  m1_req,
    output logic                 wr_done
);

    avalon_pkg::burst_t sent;
    logic               beat_ok;

    // a stalled beat keeps the filter holding its word
    assign out_ready = !avs_m1_waitrequest;
    assign beat_ok   = out_valid && out_ready;

    // dst and out_len stay fixed for the whole drain, so the burst fields hold
    assign m1_req = '{write:      out_valid,
                      address:    cfg.dst,
                      writedata:  out_word,
                      burstcount: out_len};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sent    <= '0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (beat_ok) begin
                if (sent == out_len - 1'b1) begin
                    // final beat, ready for the next burst
                    sent    <= '0;
                    wr_done <= 1'b1;
                end else begin
                    sent <= sent + 1'b1;
                end
            end
        end
    end

endmodule

// File: test/bpfcap_asserts.sv
`timescale 1ns/1ps

module bpfcap_asserts #(
    parameter int MAX_WORDS = 16
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic [2:0]              avs_s0_address,
    input logic                    avs_s0_write,
    input avalon_pkg::mm_data_t    avs_s0_writedata,
    input avalon_pkg::mm_addr_t    pkt_begin,
    input avalon_pkg::mm_addr_t    pkt_end,
    input logic                    start,
    input logic                    avs_m0_read,
    input avalon_pkg::mm_addr_t    avs_m0_address,
    input avalon_pkg::burst_t      avs_m0_burstcount,
    input logic                    avs_m0_waitrequest,
    input logic                    avs_m1_write,
    input avalon_pkg::mm_addr_t    avs_m1_address,
    input avalon_pkg::mm_data_t    avs_m1_writedata,
    input avalon_pkg::burst_t      avs_m1_burstcount,
    input logic                    avs_m1_waitrequest,
    input logic                    pkt_matched,
    input bpfcap_pkg::cap_status_t status
);

    int                 fail_count = 0;
    logic               start_wr;
    logic signed [32:0] pkt_len;
    logic               len_bad;

    assign start_wr = avs_s0_write && (avs_s0_address == bpfcap_pkg::CSR_CONTROL) &&
                      avs_s0_writedata[bpfcap_pkg::CTRL_START];

    // pkt_end below pkt_begin gives a negative length
    assign pkt_len = $signed({1'b0, pkt_end}) - $signed({1'b0, pkt_begin});
    assign len_bad = (pkt_len < 33'sd1) || (pkt_len > MAX_WORDS);

    // m0 command holds until the slave takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        (avs_m0_read && avs_m0_waitrequest) |=>
            (avs_m0_read && $stable(avs_m0_address) && $stable(avs_m0_burstcount)))
    else begin
        $error("m0 command changed while waitrequest was high");
        fail_count++;
    end

    // a stalled m1 beat keeps address, data and burstcount
    assert property (@(posedge clk) disable iff (!rst_n)
        (avs_m1_write && avs_m1_waitrequest) |=>
            (avs_m1_write && $stable(avs_m1_address) && $stable(avs_m1_writedata) &&
             $stable(avs_m1_burstcount)))
    else begin
        $error("m1 beat changed while waitrequest was high");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) avs_m1_write |-> pkt_matched)
    else begin
        $error("m1 write without a matching verdict");
        fail_count++;
    end

    // a refused start pulses nothing and issues no read
    assert property (@(posedge clk) disable iff (!rst_n)
        (start_wr && len_bad && !status.busy) |=>
            (!start && !avs_m0_read) ##1 !avs_m0_read)
    else begin
        $error("m0 read after a refused start");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(status.busy && status.done))
    else begin
        $error("busy and done high together");
        fail_count++;
    end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam logic [31:0] SEED = 32'hb22c76ba;
    localparam int MAX_WORDS = 16;
    // 6 tests of up to 16 words at 2 cycles per beat on both bursts plus polling, times 4
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int DONE_BIT = 2;
    localparam logic [31:0] ST_DONE    = 32'h4;
    localparam logic [31:0] ST_MATCHED = 32'h2;
    localparam logic [31:0] ST_ERROR   = 32'h1;

    logic        clk;
    logic        rst_n;
    logic [2:0]  avs_s0_address;
    logic        avs_s0_read;
    logic        avs_s0_write;
    logic [31:0] avs_s0_writedata;
    logic [31:0] avs_s0_readdata;
    logic [31:0] avs_m0_address;
    logic        avs_m0_read;
    logic [15:0] avs_m0_burstcount;
    logic [31:0] avs_m0_readdata;
    logic        avs_m0_readdatavalid;
    logic        avs_m0_waitrequest;
    logic [31:0] avs_m1_address;
    logic        avs_m1_write;
    logic [31:0] avs_m1_writedata;
    logic [15:0] avs_m1_burstcount;
    logic        avs_m1_waitrequest;

    logic [31:0] src_mem [256];
    logic [31:0] dst_mem [256];
    logic [31:0] fill_rng;
    logic [31:0] m0_rng;
    logic [31:0] m1_rng;
    logic [3:0]  wait_level;
    logic [31:0] m0_next_addr;
    logic [31:0] m1_base;
    logic [15:0] m0_burst;
    logic [15:0] m1_burst;
    int          m0_left;
    int          m0_cmds;
    int          m1_idx;
    int          m1_left;
    int          m1_beats;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    int          exp_count;

    bpfcap_top #(.MAX_WORDS(MAX_WORDS)) dut_i (.*);

    bind bpfcap_top bpfcap_asserts #(.MAX_WORDS(MAX_WORDS)) asserts_i (
        .clk, .rst_n, .avs_s0_address, .avs_s0_write, .avs_s0_writedata,
        .pkt_begin(csr_i.pkt_begin), .pkt_end(csr_i.pkt_end), .start,
        .avs_m0_read, .avs_m0_address, .avs_m0_burstcount, .avs_m0_waitrequest,
        .avs_m1_write, .avs_m1_address, .avs_m1_writedata, .avs_m1_burstcount,
        .avs_m1_waitrequest, .pkt_matched, .status(csr_i.status)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int total_errors();
        return errors + dut_i.asserts_i.fail_count;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the engine never reported done", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // m0 source memory whose beats are taken at the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (avs_m0_readdatavalid) begin
                m0_next_addr = m0_next_addr + 1;
                m0_left--;
            end
            if (avs_m0_read && !avs_m0_waitrequest) begin
                m0_next_addr = avs_m0_address;
                m0_left = avs_m0_burstcount;
                m0_burst = avs_m0_burstcount;
                m0_cmds++;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        m0_rng = xorshift(m0_rng);
        avs_m0_waitrequest = (m0_rng[3:0] < wait_level);
        avs_m0_readdatavalid = (m0_left > 0) && (m0_rng[7:4] >= wait_level);
        avs_m0_readdata = src_mem[m0_next_addr[7:0]];
    end

    // m1 destination memory where the first beat of a burst carries the address
    always @(negedge clk) begin
        if (rst_n && avs_m1_write && !avs_m1_waitrequest) begin
            if (m1_left == 0) begin
                m1_base = avs_m1_address;
                m1_left = avs_m1_burstcount;
                m1_burst = avs_m1_burstcount;
                m1_idx = 0;
            end
            dst_mem[8'(m1_base + m1_idx)] = avs_m1_writedata;
            m1_idx++;
            m1_left--;
            m1_beats++;
        end
    end

    always @(posedge clk) begin
        #1;
        m1_rng = xorshift(m1_rng);
        avs_m1_waitrequest = (m1_rng[3:0] < wait_level);
    end

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("Fail at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // tasks start and end 1 ns after a rising edge
    task automatic csr_write(input logic [2:0] addr, input logic [31:0] data);
        avs_s0_address = addr;
        avs_s0_writedata = data;
        avs_s0_write = 1'b1;
        @(posedge clk);
        #1;
        avs_s0_write = 1'b0;
    endtask

    task automatic csr_read(input logic [2:0] addr, output logic [31:0] data);
        avs_s0_address = addr;
        avs_s0_read = 1'b1;
        @(posedge clk);
        #1;
        avs_s0_read = 1'b0;
        data = avs_s0_readdata;
    endtask

    task automatic prepare_memories();
        for (int a = 0; a < 256; a++) begin
            fill_rng = xorshift(fill_rng);
            src_mem[a] = fill_rng ^ a;
            dst_mem[a] = 32'hdead_0000 | a;
        end
    endtask

    task automatic run_packet(input logic [31:0] pkt_begin, input logic [31:0] pkt_end,
                              input logic [31:0] dst, input logic [31:0] offset,
                              input logic [31:0] value, input logic [31:0] mask,
                              output logic [31:0] status);
        csr_write(bpfcap_pkg::CSR_PKT_BEGIN, pkt_begin);
        csr_write(bpfcap_pkg::CSR_PKT_END, pkt_end);
        csr_write(bpfcap_pkg::CSR_DST, dst);
        csr_write(bpfcap_pkg::CSR_OFFSET, offset);
        csr_write(bpfcap_pkg::CSR_VALUE, value);
        csr_write(bpfcap_pkg::CSR_MASK, mask);
        csr_write(bpfcap_pkg::CSR_CONTROL, 32'd1 << bpfcap_pkg::CTRL_START);
        status = '0;
        while (!status[DONE_BIT]) begin
            csr_read(bpfcap_pkg::CSR_CONTROL, status);
        end
    endtask

    task automatic check_result(input logic [31:0] status, input logic [31:0] exp_status,
                                input int cmds, input int beats);
        logic [31:0] count;
        expect_equal("CSR_CONTROL", exp_status, status);
        csr_read(bpfcap_pkg::CSR_COUNT, count);
        expect_equal("CSR_COUNT", exp_count, count);
        expect_equal("m0 commands", cmds, m0_cmds);
        expect_equal("m1 beats", beats, m1_beats);
    endtask

    task automatic check_copy(input logic [31:0] src, input logic [31:0] dst, input int len);
        expect_equal("avs_m0_burstcount", len, m0_burst);
        expect_equal("avs_m1_burstcount", len, m1_burst);
        for (int i = 0; i < len; i++) begin
            expect_equal($sformatf("dst_mem[0x%0h]", dst + i), src_mem[8'(src + i)],
                         dst_mem[8'(dst + i)]);
        end
        // the word after the burst stays untouched
        expect_equal($sformatf("dst_mem[0x%0h]", dst + len), 32'hdead_0000 | 8'(dst + len),
                     dst_mem[8'(dst + len)]);
    endtask

    task automatic finish_test(input string name, input int mark);
        tests_run++;
        if (total_errors() == mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     total_errors() - mark);
        end
    endtask

    initial begin : test_sequence
        logic [31:0] status;
        int          mark;
        int          cmds;
        int          beats;

        clk = 1'b0;
        rst_n = 1'b0;
        avs_s0_address = '0;
        avs_s0_read = 1'b0;
        avs_s0_write = 1'b0;
        avs_s0_writedata = '0;
        avs_m0_readdata = '0;
        avs_m0_readdatavalid = 1'b0;
        avs_m0_waitrequest = 1'b0;
        avs_m1_waitrequest = 1'b0;
        fill_rng = xorshift(xorshift(SEED));
        m0_rng = SEED;
        m1_rng = xorshift(SEED);
        wait_level = 4'd4;
        m0_next_addr = '0;
        m1_base = '0;
        m0_burst = '0;
        m1_burst = '0;
        m0_left = 0;
        m0_cmds = 0;
        m1_idx = 0;
        m1_left = 0;
        m1_beats = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        exp_count = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        mark = total_errors();
        csr_read(bpfcap_pkg::CSR_CONTROL, status);
        check_result(status, '0, 0, 0);
        expect_equal("avs_m0_read", 1'b0, avs_m0_read);
        expect_equal("avs_m1_write", 1'b0, avs_m1_write);
        finish_test("reset state", mark);

        mark = total_errors();
        prepare_memories();
        cmds = m0_cmds;
        beats = m1_beats;
        run_packet(32'h20, 32'h28, 32'h80, 32'd3, src_mem[8'h23], 32'hffff_ffff, status);
        exp_count++;
        check_result(status, ST_DONE | ST_MATCHED, cmds + 1, beats + 8);
        check_copy(32'h20, 32'h80, 8);
        finish_test("matching packet", mark);

        mark = total_errors();
        prepare_memories();
        cmds = m0_cmds;
        beats = m1_beats;
        run_packet(32'h20, 32'h28, 32'h80, 32'd3, src_mem[8'h23] ^ 32'hf0, 32'hffff_ffff,
                   status);
        check_result(status, ST_DONE, cmds + 1, beats);
        expect_equal("dst_mem[0x80]", 32'hdead_0080, dst_mem[8'h80]);
        finish_test("masked word differs", mark);

        mark = total_errors();
        prepare_memories();
        cmds = m0_cmds;
        beats = m1_beats;
        run_packet(32'h20, 32'h28, 32'h90, 32'd3, src_mem[8'h23] ^ 32'hf0, ~32'hf0, status);
        exp_count++;
        check_result(status, ST_DONE | ST_MATCHED, cmds + 1, beats + 8);
        check_copy(32'h20, 32'h90, 8);
        finish_test("mask hides difference", mark);

        mark = total_errors();
        prepare_memories();
        cmds = m0_cmds;
        beats = m1_beats;
        run_packet(32'h20, 32'h20 + MAX_WORDS + 1, 32'h80, 32'd0, 32'd0, 32'd0, status);
        check_result(status, ST_DONE | ST_ERROR, cmds, beats);
        // a zero mask would match any word that the offset reaches
        run_packet(32'h40, 32'h46, 32'h80, 32'd9, 32'd0, 32'd0, status);
        check_result(status, ST_DONE, cmds + 1, beats);
        finish_test("refused length and offset past end", mark);

        mark = total_errors();
        prepare_memories();
        cmds = m0_cmds;
        beats = m1_beats;
        wait_level = 4'd11;
        run_packet(32'h60, 32'h70, 32'ha0, 32'd15, src_mem[8'h6f], 32'hffff_0000, status);
        wait_level = 4'd4;
        exp_count++;
        check_result(status, ST_DONE | ST_MATCHED, cmds + 1, beats + 16);
        check_copy(32'h60, 32'ha0, 16);
        finish_test("full packet under heavy waitrequest", mark);

        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
